// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_lsu_top
RTL_TOP    := lsu_top
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+') testbench/tb_lsu_model.svh
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Done: no errors" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		hw/mem_pkg.sv hw/lsu_pkg.sv hw/lsu_if.sv hw/lsu_decode.sv \
		hw/lsu_execute.sv hw/lsu_result.sv hw/datamem.sv hw/lsu_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+testbench
hw/mem_pkg.sv
hw/lsu_pkg.sv
hw/lsu_if.sv
hw/lsu_decode.sv
hw/lsu_execute.sv
hw/lsu_result.sv
hw/datamem.sv
hw/lsu_top.sv
testbench/tb_lsu_top.sv

// ==== hw/datamem.sv ====
`timescale 1ns/1ps
`default_nettype none

module datamem import mem_pkg::*; #(
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	mem_port_if.dst           core,
	input  strobe_t           con_write,
	input  logic [ADDR_W-1:0] con_addr,
	input  word_t             con_in,
	output word_t             con_out
);

	localparam int DEPTH = 2 ** ADDR_W;

	// One shared array, two read/write ports
	word_t mem [DEPTH];

	logic  core_wr;
	logic  con_wr;
	logic  same_word;
	word_t con_word;
	word_t core_word;

	assign core_wr   = core.en & (|core.we);
	assign con_wr    = |con_write;
	assign same_word = core_wr & con_wr & (core.addr == con_addr);

	// Controller bytes merged first
	assign con_word = merge_word(mem[con_addr], con_in, con_write);

	// On a same-word collision, start from the controller result
	// so its other bytes still land and core bytes win
	assign core_word = merge_word(same_word ? con_word : mem[core.addr], core.din, core.we);

	always_ff @(posedge clk) begin
		if (con_wr) begin
			mem[con_addr] <= con_word;
		end
		// Later write wins when both hit the same word
		if (core_wr) begin
			mem[core.addr] <= core_word;
		end
	end

	// Read-first, old word returned
	// core dout only moves on an enabled access
	always_ff @(posedge clk) begin
		if (core.en) begin
			core.dout <= mem[core.addr];
		end
	end

	// Controller port always enabled
	always_ff @(posedge clk) begin
		con_out <= mem[con_addr];
	end

endmodule

`default_nettype wire

// ==== hw/lsu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_decode import mem_pkg::*, lsu_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    req_valid,
	input  logic    req_store,
	input  funct3_e req_funct3,
	input  word_t   req_base,
	input  imm_t    req_imm,
	input  word_t   req_wdata,
	input  rd_t     req_rd,
	output logic    req_ready,
	lsu_req_if.src  req
);

	logic  ready_q;
	logic  take;
	size_e dec_size;
	logic  dec_sign;

	// Slot empty or draining this cycle
	// Held off for the first cycle out of reset
	assign req_ready = ready_q & (~req.valid | req.ready);
	assign take = req_valid & req_ready;

	// funct3 to width and sign
	always_comb begin
		dec_size = WORD;
		dec_sign = 1'b0;
		case (req_funct3)
			LB: begin
				dec_size = BYTE;
				dec_sign = 1'b1;
			end
			LH: begin
				dec_size = HALF;
				dec_sign = 1'b1;
			end
			LBU: dec_size = BYTE;
			LHU: dec_size = HALF;
			// LW and unused codes fall back to a word access
			default: dec_size = WORD;
		endcase
		// Stores never extend
		if (req_store) begin
			dec_sign = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_q   <= 1'b0;
			req.valid <= 1'b0;
		end else begin
			ready_q <= 1'b1;
			if (take) begin
				req.valid <= 1'b1;
			end else if (req.ready) begin
				req.valid <= 1'b0;
			end
		end
	end

	// Request fields, qualified by valid
	always_ff @(posedge clk) begin
		if (take) begin
			req.store <= req_store;
			req.size  <= dec_size;
			req.sign  <= dec_sign;
			req.base  <= req_base;
			req.imm   <= req_imm;
			req.wdata <= req_wdata;
			req.rd    <= req_rd;
		end
	end

endmodule

`default_nettype wire

// ==== hw/lsu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_execute import mem_pkg::*, lsu_pkg::*; #(
	parameter int ADDR_W = 10
) (
	input  logic    clk,
	input  logic    rst_n,
	lsu_req_if.dst  req,
	lsu_pend_if.src pend,
	mem_port_if.src mem
);

	word_t             eff_addr;
	offset_t           offset;
	logic [ADDR_W-1:0] word_addr;
	logic              misal;
	logic              take;
	logic              do_access;
	strobe_t           lane_strb;
	word_t             lane_data;

	// Advance only if the pending slot is free or drains now
	// A stall here means no memory access at all
	assign req.ready = ~pend.valid | pend.ready;
	assign take = req.valid & req.ready;

	// Base plus sign-extended immediate
	assign eff_addr = req.base + {{20{req.imm[11]}}, req.imm};

	// Byte offset, then word index
	// bits above ADDR_W+1 are dropped
	assign offset    = eff_addr[1:0];
	assign word_addr = eff_addr[ADDR_W+1:2];

	assign misal = is_misaligned(req.size, offset);

	// Misaligned requests still take a slot but skip the memory
	assign do_access = take & ~misal;

	// Replicate store data across lanes
	always_comb begin
		case (req.size)
			BYTE: begin
				lane_strb = STRB_BYTE;
				lane_data = {4{req.wdata[7:0]}};
			end
			HALF: begin
				lane_strb = STRB_HALF;
				lane_data = {2{req.wdata[15:0]}};
			end
			default: begin
				lane_strb = STRB_WORD;
				lane_data = req.wdata;
			end
		endcase
	end

	// Core memory port
	assign mem.en   = do_access;
	assign mem.we   = (do_access & req.store) ? strobe_t'(lane_strb << offset) : '0;
	assign mem.addr = word_addr;
	assign mem.din  = lane_data;

	// Pending record, lines up with mem.dout next cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend.valid <= 1'b0;
		end else if (take) begin
			pend.valid <= 1'b1;
		end else if (pend.ready) begin
			pend.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pend.store  <= req.store;
			pend.fault  <= misal;
			pend.size   <= req.size;
			pend.sign   <= req.sign;
			pend.offset <= offset;
			pend.rd     <= req.rd;
		end
	end

	// Memory dout holds while en is low, so a stalled record keeps its data

endmodule

`default_nettype wire

// ==== hw/lsu_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decoded request, decode to execute
interface lsu_req_if import mem_pkg::*, lsu_pkg::*;;
	logic  valid;
	logic  ready;
	logic  store;
	size_e size;
	logic  sign;
	word_t base;
	imm_t  imm;
	word_t wdata;
	rd_t   rd;

	modport src (output valid, store, size, sign, base, imm, wdata, rd, input ready);
	modport dst (input valid, store, size, sign, base, imm, wdata, rd, output ready);
endinterface

// Access in flight, execute to result
interface lsu_pend_if import lsu_pkg::*;;
	logic    valid;
	logic    ready;
	logic    store;
	logic    fault;
	size_e   size;
	logic    sign;
	offset_t offset;
	rd_t     rd;

	modport src (output valid, store, fault, size, sign, offset, rd, input ready);
	modport dst (input valid, store, fault, size, sign, offset, rd, output ready);
endinterface

// Core side of the data memory
interface mem_port_if import mem_pkg::*; #(
	parameter int ADDR_W = 10
);
	logic              en;
	strobe_t           we;
	logic [ADDR_W-1:0] addr;
	word_t             din;
	// Valid one cycle after en
	word_t             dout;

	modport src (output en, we, addr, din, input dout);
	modport dst (input en, we, addr, din, output dout);
endinterface

`default_nettype wire

// ==== hw/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

	// Load funct3 codes
	// SB, SH and SW share the LB, LH and LW codes
	typedef enum logic [2:0] {
		LB  = 3'b000,
		LH  = 3'b001,
		LW  = 3'b010,
		LBU = 3'b100,
		LHU = 3'b101
	} funct3_e;

	// Access width after decode
	typedef enum logic [1:0] {
		BYTE = 2'd0,
		HALF = 2'd1,
		WORD = 2'd2
	} size_e;

	// Byte offset inside a word
	typedef logic [1:0] offset_t;

	// Destination register tag, carried back with the response
	typedef logic [4:0] rd_t;

	// I/S-type immediate
	typedef logic signed [11:0] imm_t;

	// Halves need an even offset, words need offset 0
	function automatic logic is_misaligned(size_e size, offset_t offset);
		case (size)
			BYTE:    return 1'b0;
			HALF:    return offset[0];
			default: return |offset;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== hw/lsu_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_result import mem_pkg::*, lsu_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	lsu_pend_if.dst pend,
	input  word_t   mem_dout,
	output logic    rsp_valid,
	input  logic    rsp_ready,
	output word_t   rsp_data,
	output rd_t     rsp_rd,
	output logic    rsp_store,
	output logic    rsp_fault
);

	logic  take;
	word_t lane;
	word_t ext;

	// Single response register, held while rsp_ready is low
	assign pend.ready = ~rsp_valid | rsp_ready;
	assign take = pend.valid & pend.ready;

	// Move the addressed lane down to bit 0
	assign lane = mem_dout >> {pend.offset, 3'b000};

	always_comb begin
		case (pend.size)
			BYTE: ext = pend.sign ? {{24{lane[7]}}, lane[7:0]} : {24'b0, lane[7:0]};
			HALF: ext = pend.sign ? {{16{lane[15]}}, lane[15:0]} : {16'b0, lane[15:0]};
			default: ext = mem_dout;
		endcase
		// Stores and faults return zero
		if (pend.store | pend.fault) begin
			ext = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
		end else if (take) begin
			rsp_valid <= 1'b1;
		end else if (rsp_ready) begin
			rsp_valid <= 1'b0;
		end
	end

	// Response payload
	always_ff @(posedge clk) begin
		if (take) begin
			rsp_data  <= ext;
			rsp_rd    <= pend.rd;
			rsp_store <= pend.store;
			rsp_fault <= pend.fault;
		end
	end

endmodule

`default_nettype wire

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top import mem_pkg::*, lsu_pkg::*; #(
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	input  logic              rst_n,

	// Core request
	input  logic              req_valid,
	output logic              req_ready,
	input  logic              req_store,
	input  funct3_e           req_funct3,
	input  word_t             req_base,
	input  imm_t              req_imm,
	input  word_t             req_wdata,
	input  rd_t               req_rd,

	// Core response
	output logic              rsp_valid,
	input  logic              rsp_ready,
	output word_t             rsp_data,
	output rd_t               rsp_rd,
	output logic              rsp_store,
	output logic              rsp_fault,

	// Protocol controller port, no handshake
	input  strobe_t           con_write,
	input  logic [ADDR_W-1:0] con_addr,
	input  word_t             con_in,
	output word_t             con_out
);

	lsu_req_if                         req_bus ();
	lsu_pend_if                        pend_bus ();
	mem_port_if #(.ADDR_W(ADDR_W))     mem_bus ();

	// Request register and funct3 decode
	lsu_decode u_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_store  (req_store),
		.req_funct3 (req_funct3),
		.req_base   (req_base),
		.req_imm    (req_imm),
		.req_wdata  (req_wdata),
		.req_rd     (req_rd),
		.req_ready  (req_ready),
		.req        (req_bus.src)
	);

	// Address, alignment and memory access
	lsu_execute #(.ADDR_W(ADDR_W)) u_execute (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req_bus.dst),
		.pend  (pend_bus.src),
		.mem   (mem_bus.src)
	);

	// Lane select, extension and response hold
	lsu_result u_result (
		.clk       (clk),
		.rst_n     (rst_n),
		.pend      (pend_bus.dst),
		.mem_dout  (mem_bus.dout),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_data  (rsp_data),
		.rsp_rd    (rsp_rd),
		.rsp_store (rsp_store),
		.rsp_fault (rsp_fault)
	);

	datamem #(.ADDR_W(ADDR_W)) u_datamem (
		.clk       (clk),
		.core      (mem_bus.dst),
		.con_write (con_write),
		.con_addr  (con_addr),
		.con_in    (con_in),
		.con_out   (con_out)
	);

endmodule

`default_nettype wire

// ==== hw/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// One memory word and its byte lanes
	typedef logic [31:0] word_t;
	typedef logic [3:0]  strobe_t;

	// Lane enables at offset 0, shifted by the byte offset later
	localparam strobe_t STRB_BYTE = 4'b0001;
	localparam strobe_t STRB_HALF = 4'b0011;
	localparam strobe_t STRB_WORD = 4'b1111;

	// Expand each strobe bit to a full byte mask
	function automatic word_t strobe_mask(strobe_t strb);
		word_t mask;
		for (int i = 0; i < 4; i++) begin
			mask[8*i +: 8] = {8{strb[i]}};
		end
		return mask;
	endfunction

	// Strobed bytes from new_word, the rest kept from old_word
	function automatic word_t merge_word(word_t old_word, word_t new_word, strobe_t strb);
		word_t mask;
		mask = strobe_mask(strb);
		return (old_word & ~mask) | (new_word & mask);
	endfunction

endpackage

`default_nettype wire

// ==== testbench/tb_lsu_model.svh ====
`ifndef TB_LSU_MODEL_SVH
`define TB_LSU_MODEL_SVH

// Shadow of the data memory, one entry per word
logic [31:0] shadow [1024];

// Start value for a word, built from the full word address
function automatic logic [31:0] fill_word(int a);
	return {a[9:0], 6'h15, ~a[9:0], 6'h2a};
endfunction

// Controller write, only strobed bytes change
function automatic void ctl_write(int a, logic [3:0] strb, logic [31:0] d);
	for (int i = 0; i < 4; i++) begin
		if (strb[i]) begin
			shadow[a][8*i +: 8] = d[8*i +: 8];
		end
	end
endfunction

// One core load or store, applied in request order
function automatic void core_access(input logic store, input logic [2:0] f3,
		input logic [31:0] base, input logic [11:0] imm, input logic [31:0] wdata,
		output logic [31:0] data, output logic fault);
	logic [31:0] eff;
	logic [31:0] w;
	int          off;
	int          idx;
	int          nbytes;
	logic        sgn;
	eff    = base + {{20{imm[11]}}, imm};
	off    = int'(eff[1:0]);
	idx    = int'(eff[11:2]);
	// Byte codes 0 and 4, half codes 1 and 5, everything else a word
	nbytes = (f3 == 3'd0 || f3 == 3'd4) ? 1 : ((f3 == 3'd1 || f3 == 3'd5) ? 2 : 4);
	sgn    = !store && (f3 == 3'd0 || f3 == 3'd1);
	fault  = (nbytes == 2 && off % 2 == 1) || (nbytes == 4 && off != 0);
	data   = '0;
	if (!fault) begin
		if (store) begin
			for (int i = 0; i < nbytes; i++) begin
				shadow[idx][8*(off+i) +: 8] = wdata[8*i +: 8];
			end
		end else begin
			w = shadow[idx] >> (8 * off);
			if (nbytes == 1) begin
				data = sgn ? {{24{w[7]}}, w[7:0]} : {24'h0, w[7:0]};
			end else if (nbytes == 2) begin
				data = sgn ? {{16{w[15]}}, w[15:0]} : {16'h0, w[15:0]};
			end else begin
				data = w;
			end
		end
	end
endfunction

`endif

// ==== testbench/tb_lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top import mem_pkg::*, lsu_pkg::*;;

	localparam int ADDR_W  = 10;
	localparam int PERIOD  = 100;
	localparam int WIN     = 16;
	localparam int N_RAND  = 400;
	localparam int N_LAT   = 150;
	localparam int N_HI    = 120;
	localparam int N_CTL   = 40;
	localparam int NUM_REQ = N_RAND + N_LAT + N_HI + 2 * N_CTL + 2 * WIN;

	logic              clk;
	logic              rst_n;
	logic              req_valid;
	logic              req_ready;
	logic              req_store;
	funct3_e           req_funct3;
	word_t             req_base;
	imm_t              req_imm;
	word_t             req_wdata;
	rd_t               req_rd;
	logic              rsp_valid;
	logic              rsp_ready;
	word_t             rsp_data;
	rd_t               rsp_rd;
	logic              rsp_store;
	logic              rsp_fault;
	strobe_t           con_write;
	logic [ADDR_W-1:0] con_addr;
	word_t             con_in;
	word_t             con_out;

	`include "tb_lsu_model.svh"

	// Expected response, with the cycle it was accepted in
	typedef struct {
		logic [31:0] data;
		logic [4:0]  rd;
		logic        store;
		logic        fault;
		int          cyc;
	} exp_t;

	exp_t exp_q[$];

	integer      seed = 32'h577c;
	int          cycle = 0;
	int          rsp_errs = 0;
	int          con_errs = 0;
	int          proto_errs = 0;
	logic        req_fire = 1'b0;
	logic        con_chk_prev = 1'b0;
	logic [31:0] con_exp;

	// Phase controls
	logic allow_new = 1'b0;
	logic core_hi = 1'b0;
	logic ready_rand = 1'b0;
	logic ctl_on = 1'b0;
	logic ctl_wr = 1'b0;
	logic check_lat = 1'b0;

	lsu_top #(.ADDR_W(ADDR_W)) UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_store  (req_store),
		.req_funct3 (req_funct3),
		.req_base   (req_base),
		.req_imm    (req_imm),
		.req_wdata  (req_wdata),
		.req_rd     (req_rd),
		.rsp_valid  (rsp_valid),
		.rsp_ready  (rsp_ready),
		.rsp_data   (rsp_data),
		.rsp_rd     (rsp_rd),
		.rsp_store  (rsp_store),
		.rsp_fault  (rsp_fault),
		.con_write  (con_write),
		.con_addr   (con_addr),
		.con_in     (con_in),
		.con_out    (con_out)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	// Random load or store inside a small word window
	task automatic new_request(input logic hi);
		int          word;
		int          off;
		logic [31:0] target;
		word       = int'({$random(seed)} % WIN) + (hi ? 512 : 0);
		off        = int'({$random(seed)} % 4);
		target     = 32'(word * 4 + off);
		req_imm    = imm_t'($random(seed) % 64);
		// Bits above the word address are junk, DUT drops them
		req_base   = target - {{20{req_imm[11]}}, req_imm} + (32'({$random(seed)} % 8) << 12);
		req_store  = ({$random(seed)} % 2) == 0;
		req_funct3 = funct3_e'(3'($random(seed)));
		req_wdata  = $random(seed);
		req_rd     = rd_t'($random(seed));
	endtask

	// One clock: drive on the falling edge, check shortly after
	task automatic step();
		exp_t        e;
		logic [31:0] d;
		logic        f;
		@(negedge clk);
		rsp_ready = ready_rand ? (({$random(seed)} % 4) != 0) : 1'b1;
		// Hold a request until it is taken
		if (!req_valid || req_fire) begin
			req_valid = 1'b0;
			if (allow_new && ({$random(seed)} % 4) != 0) begin
				new_request(core_hi);
				req_valid = 1'b1;
			end
		end
		con_write = '0;
		if (ctl_on) begin
			con_addr = 10'(512 + {$random(seed)} % WIN);
			if (ctl_wr && ({$random(seed)} % 2) == 0) begin
				con_write = strobe_t'($random(seed));
				con_in    = $random(seed);
			end
		end
		#(PERIOD/10);
		if (con_chk_prev) begin
			assert (con_out === con_exp) else begin
				$display("FAILED at %0t: con_out %h, expected %h", $time, con_out, con_exp);
				con_errs++;
			end
		end
		// Read-first, so the next con_out shows the word before this write
		con_chk_prev = ctl_on;
		con_exp = shadow[con_addr];
		if (con_write != 4'h0) begin
			ctl_write(int'(con_addr), con_write, con_in);
		end
		assert (!rsp_valid || exp_q.size() > 0) else begin
			$display("Response valid at %0t with no request outstanding", $time);
			proto_errs++;
		end
		if (rsp_valid && rsp_ready && exp_q.size() > 0) begin
			e = exp_q.pop_front();
			assert (rsp_data === e.data && rsp_rd === e.rd && rsp_store === e.store &&
					rsp_fault === e.fault) else begin
				$display("FAILED at %0t: rsp data %h rd %0d st %b flt %b, expected %h %0d %b %b",
					$time, rsp_data, rsp_rd, rsp_store, rsp_fault,
					e.data, e.rd, e.store, e.fault);
				rsp_errs++;
			end
			if (check_lat) begin
				assert (cycle - e.cyc == 3) else begin
					$display("FAILED at %0t: latency %0d cycles, expected 3", $time,
						cycle - e.cyc);
					proto_errs++;
				end
			end
		end
		req_fire = req_valid & req_ready;
		if (req_fire) begin
			core_access(req_store, req_funct3, req_base, req_imm, req_wdata, d, f);
			e.data  = d;
			e.rd    = req_rd;
			e.store = req_store;
			e.fault = f;
			e.cyc   = cycle;
			exp_q.push_back(e);
		end
		cycle++;
	endtask

	// Stop new requests and let the pipeline empty
	task automatic drain();
		allow_new = 1'b0;
		while (req_valid || exp_q.size() != 0) begin
			step();
		end
	endtask

	// Known contents in both windows through the controller port
	task automatic init_memory();
		int a;
		for (int i = 0; i < 2 * WIN; i++) begin
			a = (i < WIN) ? i : 512 + i - WIN;
			@(negedge clk);
			con_addr  = 10'(a);
			con_write = 4'hf;
			con_in    = fill_word(a);
			ctl_write(a, 4'hf, fill_word(a));
			// Ready from the second cycle on, still no response
			#(PERIOD/10);
			assert (req_ready && !rsp_valid) else begin
				$display("Request not ready or response valid before any request at %0t",
					$time);
				proto_errs++;
			end
		end
		@(negedge clk);
		con_write = '0;
	endtask

	// Watchdog
	initial begin
		repeat (NUM_REQ * 20) @(posedge clk);
		$display("Timeout: the test did not finish in the expected time");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		rst_n      = 1'b0;
		req_valid  = 1'b0;
		req_store  = 1'b0;
		req_funct3 = LW;
		req_base   = '0;
		req_imm    = '0;
		req_wdata  = '0;
		req_rd     = '0;
		rsp_ready  = 1'b1;
		con_write  = '0;
		con_addr   = '0;
		con_in     = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#(PERIOD/10);
		// First cycle out of reset
		assert (!req_ready && !rsp_valid) else begin
			$display("Request ready or response valid right after reset");
			proto_errs++;
		end
		init_memory();
		// Mixed traffic, back-pressure, controller busy in the upper half
		ready_rand = 1'b1;
		ctl_on     = 1'b1;
		ctl_wr     = 1'b1;
		allow_new  = 1'b1;
		repeat (N_RAND) step();
		drain();
		// No back-pressure, fixed latency
		ready_rand = 1'b0;
		ctl_on     = 1'b0;
		check_lat  = 1'b1;
		allow_new  = 1'b1;
		repeat (N_LAT) step();
		drain();
		check_lat = 1'b0;
		// Controller writes upper half, core then reads and writes there
		ctl_on = 1'b1;
		repeat (N_CTL) step();
		ctl_on     = 1'b0;
		core_hi    = 1'b1;
		ready_rand = 1'b1;
		allow_new  = 1'b1;
		repeat (N_HI) step();
		drain();
		// Core stores seen from the controller side
		ctl_on = 1'b1;
		ctl_wr = 1'b0;
		repeat (N_CTL) step();
		ctl_on = 1'b0;
		step();
		$display("Errors: %0d response, %0d controller, %0d protocol",
			rsp_errs, con_errs, proto_errs);
		if (rsp_errs + con_errs + proto_errs == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
